/* logic/lc3b_config.svh */
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// datapath word
`define LC3B_WORD_W 16

`define LC3B_NUM_REGS 8

// first fetch after reset
`define LC3B_RESET_PC 16'h0000

`endif

/* logic/lc3b_types.sv */
`include "lc3b_config.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;

    // other encodings retire as bubbles
    typedef enum logic [3:0] {
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_not = 4'b1001,
        op_ldr = 4'b0110,
        op_str = 4'b0111
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not
    } lc3b_aluop;

    typedef struct packed {
        lc3b_aluop aluop;
        logic imm_sel;
        logic load;
        logic store;
        logic reg_write;
    } lc3b_control_word;

    typedef struct packed {
        lc3b_word ir;
        lc3b_word pc;
    } lc3b_f_de_t;

    typedef struct packed {
        lc3b_control_word cw;
        lc3b_word sr1;
        lc3b_word sr2;
        lc3b_word imm;
        lc3b_reg dr;
    } lc3b_de_ex_t;

    typedef struct packed {
        lc3b_control_word cw;
        lc3b_word result;
        lc3b_word store_data;
        lc3b_reg dr;
    } lc3b_ex_mem_t;

    typedef struct packed {
        lc3b_word value;
        lc3b_reg dr;
        logic reg_write;
    } lc3b_mem_wb_t;

endpackage

/* logic/mem_port_if.sv */
`timescale 1ns/1ps

interface mem_port_if;

    logic read;
    logic write;
    lc3b_types::lc3b_word address;
    lc3b_types::lc3b_word wdata;
    lc3b_types::lc3b_word rdata;
    logic resp;

    // request held until a one-cycle resp
    modport requester (
        output read, write, address, wdata,
        input rdata, resp
    );

    modport arbiter (
        input read, write, address, wdata,
        output rdata, resp
    );

endinterface

/* logic/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input logic clk,
    input logic reset,
    input logic load,
    input logic bubble,
    input payload_t in,
    input logic in_valid,
    output payload_t out,
    output logic out_valid
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= in_valid && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            out <= in;
        end
    end

endmodule

/* logic/fetch.sv */
`timescale 1ns/1ps
`include "lc3b_config.svh"

module fetch (
    input logic clk,
    input logic reset,
    input logic load_regs,
    input logic dep_stall,
    mem_port_if.requester port,
    output lc3b_types::lc3b_f_de_t f_de,
    output logic f_de_valid
);

    lc3b_types::lc3b_word pc;
    logic armed;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `LC3B_RESET_PC;
            armed <= 1'b0;
        end else begin
            armed <= 1'b1;
            // pc holds while decode is stalled
            if (load_regs && !dep_stall) begin
                pc <= pc + lc3b_types::lc3b_word'(2);
            end
        end
    end

    assign port.read = armed;
    assign port.write = 1'b0;
    assign port.address = pc;
    assign port.wdata = '0;

    // fetch resp is always the last one in a step
    assign f_de.ir = port.rdata;
    assign f_de.pc = pc;
    assign f_de_valid = port.resp;

endmodule

/* logic/decode.sv */
`timescale 1ns/1ps
`include "lc3b_config.svh"

module decode (
    input logic clk,
    input logic reset,
    input logic load_regs,
    input lc3b_types::lc3b_f_de_t f_de,
    input logic f_de_valid,
    input lc3b_types::lc3b_reg de_ex_dr,
    input logic de_ex_wr,
    input lc3b_types::lc3b_reg ex_mem_dr,
    input logic ex_mem_wr,
    input lc3b_types::lc3b_mem_wb_t mem_wb,
    input logic mem_wb_valid,
    output lc3b_types::lc3b_de_ex_t de_ex,
    output logic de_ex_valid,
    output logic dep_stall
);

    lc3b_types::lc3b_word regfile [`LC3B_NUM_REGS];
    lc3b_types::lc3b_opcode opcode;
    lc3b_types::lc3b_control_word cw;
    lc3b_types::lc3b_reg sr1;
    lc3b_types::lc3b_reg sr2;
    logic known_op;
    logic uses_sr2;

    // any older instruction still to write r
    function automatic logic pending_write(input lc3b_types::lc3b_reg r);
        return (de_ex_wr && de_ex_dr == r)
            || (ex_mem_wr && ex_mem_dr == r)
            || (mem_wb_valid && mem_wb.reg_write && mem_wb.dr == r);
    endfunction

    always_comb begin
        opcode = lc3b_types::lc3b_opcode'(f_de.ir[15:12]);
        cw = '0;
        known_op = 1'b1;
        uses_sr2 = 1'b0;
        case (opcode)
            lc3b_types::op_add, lc3b_types::op_and: begin
                cw.aluop = (opcode == lc3b_types::op_and) ? lc3b_types::alu_and
                                                          : lc3b_types::alu_add;
                cw.imm_sel = f_de.ir[5];
                cw.reg_write = 1'b1;
                uses_sr2 = !f_de.ir[5];
            end
            lc3b_types::op_not: begin
                cw.aluop = lc3b_types::alu_not;
                cw.reg_write = 1'b1;
            end
            lc3b_types::op_ldr: begin
                cw.imm_sel = 1'b1;
                cw.load = 1'b1;
                cw.reg_write = 1'b1;
            end
            lc3b_types::op_str: begin
                cw.imm_sel = 1'b1;
                cw.store = 1'b1;
                uses_sr2 = 1'b1;
            end
            default: begin
                known_op = 1'b0;
            end
        endcase

        // STR carries its source register in the dr field
        sr1 = f_de.ir[8:6];
        sr2 = cw.store ? f_de.ir[11:9] : f_de.ir[2:0];

        de_ex.cw = cw;
        de_ex.sr1 = regfile[sr1];
        de_ex.sr2 = regfile[sr2];
        if (cw.load || cw.store) begin
            de_ex.imm = {{(`LC3B_WORD_W-7){f_de.ir[5]}}, f_de.ir[5:0], 1'b0};
        end else begin
            de_ex.imm = {{(`LC3B_WORD_W-5){f_de.ir[4]}}, f_de.ir[4:0]};
        end
        de_ex.dr = f_de.ir[11:9];

        de_ex_valid = f_de_valid && known_op;
        dep_stall = de_ex_valid
            && (pending_write(sr1) || (uses_sr2 && pending_write(sr2)));
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LC3B_NUM_REGS; i++) begin
                regfile[i] <= '0;
            end
        end else if (load_regs && mem_wb_valid && mem_wb.reg_write) begin
            regfile[mem_wb.dr] <= mem_wb.value;
        end
    end

endmodule

/* logic/execute.sv */
`timescale 1ns/1ps

module execute (
    input lc3b_types::lc3b_de_ex_t ex_in,
    input logic ex_in_valid,
    output lc3b_types::lc3b_ex_mem_t ex_out,
    output logic ex_out_valid
);

    lc3b_types::lc3b_word operand_b;
    lc3b_types::lc3b_word alu_out;

    // LDR and STR take the offset here, giving base plus offset
    assign operand_b = ex_in.cw.imm_sel ? ex_in.imm : ex_in.sr2;

    always_comb begin
        case (ex_in.cw.aluop)
            lc3b_types::alu_and: begin
                alu_out = ex_in.sr1 & operand_b;
            end
            lc3b_types::alu_not: begin
                alu_out = ~ex_in.sr1;
            end
            default: begin
                alu_out = ex_in.sr1 + operand_b;
            end
        endcase
    end

    assign ex_out.cw = ex_in.cw;
    assign ex_out.result = alu_out;
    assign ex_out.store_data = ex_in.sr2;
    assign ex_out.dr = ex_in.dr;
    assign ex_out_valid = ex_in_valid;

endmodule

/* logic/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
    input lc3b_types::lc3b_ex_mem_t ex_mem,
    input logic ex_mem_valid,
    mem_port_if.requester port,
    output lc3b_types::lc3b_mem_wb_t mem_wb,
    output logic mem_wb_valid
);

    logic do_load;
    logic do_store;

    assign do_load = ex_mem_valid && ex_mem.cw.load;
    assign do_store = ex_mem_valid && ex_mem.cw.store;

    // held for the whole step, arbiter masks it once served
    assign port.read = do_load;
    assign port.write = do_store;
    assign port.address = ex_mem.result;
    assign port.wdata = ex_mem.store_data;

    // write-back select
    assign mem_wb.value = ex_mem.cw.load ? port.rdata : ex_mem.result;
    assign mem_wb.dr = ex_mem.dr;
    assign mem_wb.reg_write = ex_mem.cw.reg_write;
    assign mem_wb_valid = ex_mem_valid;

endmodule

/* logic/arbiter.sv */
`timescale 1ns/1ps

module arbiter (
    input logic clk,
    input logic reset,
    mem_port_if.arbiter ifetch,
    mem_port_if.arbiter data,
    input logic pmem_resp,
    input lc3b_types::lc3b_word pmem_rdata,
    output logic pmem_read,
    output logic pmem_write,
    output lc3b_types::lc3b_word pmem_address,
    output lc3b_types::lc3b_word pmem_wdata,
    output logic load_regs
);

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_fetch
    } owner_t;

    owner_t state;
    owner_t owner;
    logic data_done;
    logic data_req;
    logic fetch_req;
    logic data_complete;
    lc3b_types::lc3b_word data_buf;

    assign data_req = (data.read || data.write) && !data_done;
    assign fetch_req = ifetch.read || ifetch.write;

    // idle grants in the same cycle with data first
    always_comb begin
        owner = state;
        if (state == st_idle) begin
            if (data_req) begin
                owner = st_data;
            end else if (fetch_req) begin
                owner = st_fetch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            data_done <= 1'b0;
        end else begin
            state <= pmem_resp ? st_idle : owner;
            if (load_regs) begin
                data_done <= 1'b0;
            end else if (data.resp) begin
                data_done <= 1'b1;
            end
        end
    end

    // load data must survive until the step ends
    always_ff @(posedge clk) begin
        if (data.resp) begin
            data_buf <= pmem_rdata;
        end
    end

    always_comb begin
        pmem_read = 1'b0;
        pmem_write = 1'b0;
        pmem_address = ifetch.address;
        pmem_wdata = ifetch.wdata;
        case (owner)
            st_data: begin
                pmem_read = data.read;
                pmem_write = data.write;
                pmem_address = data.address;
                pmem_wdata = data.wdata;
            end
            st_fetch: begin
                pmem_read = ifetch.read;
                pmem_write = ifetch.write;
            end
            default: begin
            end
        endcase
    end

    assign data.resp = (owner == st_data) && pmem_resp;
    assign ifetch.resp = (owner == st_fetch) && pmem_resp;
    assign data.rdata = data_done ? data_buf : pmem_rdata;
    assign ifetch.rdata = pmem_rdata;

    // step ends on the fetch resp once any data access is in
    assign data_complete = !(data.read || data.write) || data_done;
    assign load_regs = ifetch.resp && data_complete;

endmodule

/* logic/mp3.sv */
`timescale 1ns/1ps

module mp3 (
    input logic clk,
    input logic reset,
    input logic pmem_resp,
    input lc3b_types::lc3b_word pmem_rdata,
    output logic pmem_read,
    output logic pmem_write,
    output lc3b_types::lc3b_word pmem_address,
    output lc3b_types::lc3b_word pmem_wdata
);

    mem_port_if ifetch_port ();
    mem_port_if data_port ();

    logic load_regs;
    logic dep_stall;

    lc3b_types::lc3b_f_de_t f_de_d;
    lc3b_types::lc3b_f_de_t f_de_q;
    logic f_de_d_valid;
    logic f_de_q_valid;

    lc3b_types::lc3b_de_ex_t de_ex_d;
    lc3b_types::lc3b_de_ex_t de_ex_q;
    logic de_ex_d_valid;
    logic de_ex_q_valid;

    lc3b_types::lc3b_ex_mem_t ex_mem_d;
    lc3b_types::lc3b_ex_mem_t ex_mem_q;
    logic ex_mem_d_valid;
    logic ex_mem_q_valid;

    lc3b_types::lc3b_mem_wb_t mem_wb_d;
    lc3b_types::lc3b_mem_wb_t mem_wb_q;
    logic mem_wb_d_valid;
    logic mem_wb_q_valid;

    fetch fetch_int (
        .clk,
        .reset,
        .load_regs,
        .dep_stall,
        .port(ifetch_port.requester),
        .f_de(f_de_d),
        .f_de_valid(f_de_d_valid)
    );

    // f_de holds while decode is stalled
    pipe_reg #(.payload_t(lc3b_types::lc3b_f_de_t)) f_de_reg (
        .clk,
        .reset,
        .load(load_regs && !dep_stall),
        .bubble(1'b0),
        .in(f_de_d),
        .in_valid(f_de_d_valid),
        .out(f_de_q),
        .out_valid(f_de_q_valid)
    );

    decode decode_int (
        .clk,
        .reset,
        .load_regs,
        .f_de(f_de_q),
        .f_de_valid(f_de_q_valid),
        .de_ex_dr(de_ex_q.dr),
        .de_ex_wr(de_ex_q_valid && de_ex_q.cw.reg_write),
        .ex_mem_dr(ex_mem_q.dr),
        .ex_mem_wr(ex_mem_q_valid && ex_mem_q.cw.reg_write),
        .mem_wb(mem_wb_q),
        .mem_wb_valid(mem_wb_q_valid),
        .de_ex(de_ex_d),
        .de_ex_valid(de_ex_d_valid),
        .dep_stall
    );

    pipe_reg #(.payload_t(lc3b_types::lc3b_de_ex_t)) de_ex_reg (
        .clk,
        .reset,
        .load(load_regs),
        .bubble(dep_stall),
        .in(de_ex_d),
        .in_valid(de_ex_d_valid),
        .out(de_ex_q),
        .out_valid(de_ex_q_valid)
    );

    execute execute_int (
        .ex_in(de_ex_q),
        .ex_in_valid(de_ex_q_valid),
        .ex_out(ex_mem_d),
        .ex_out_valid(ex_mem_d_valid)
    );

    pipe_reg #(.payload_t(lc3b_types::lc3b_ex_mem_t)) ex_mem_reg (
        .clk,
        .reset,
        .load(load_regs),
        .bubble(1'b0),
        .in(ex_mem_d),
        .in_valid(ex_mem_d_valid),
        .out(ex_mem_q),
        .out_valid(ex_mem_q_valid)
    );

    mem_stage mem_int (
        .ex_mem(ex_mem_q),
        .ex_mem_valid(ex_mem_q_valid),
        .port(data_port.requester),
        .mem_wb(mem_wb_d),
        .mem_wb_valid(mem_wb_d_valid)
    );

    pipe_reg #(.payload_t(lc3b_types::lc3b_mem_wb_t)) mem_wb_reg (
        .clk,
        .reset,
        .load(load_regs),
        .bubble(1'b0),
        .in(mem_wb_d),
        .in_valid(mem_wb_d_valid),
        .out(mem_wb_q),
        .out_valid(mem_wb_q_valid)
    );

    arbiter arbiter_int (
        .clk,
        .reset,
        .ifetch(ifetch_port.arbiter),
        .data(data_port.arbiter),
        .pmem_resp,
        .pmem_rdata,
        .pmem_read,
        .pmem_write,
        .pmem_address,
        .pmem_wdata,
        .load_regs
    );

endmodule

/* dv/mp3_checker.sv */
`timescale 1ns/1ps
`include "lc3b_config.svh"

module mp3_checker (
    input logic clk,
    input logic reset,
    input logic pmem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic [`LC3B_WORD_W-1:0] pmem_address,
    input logic [`LC3B_WORD_W-1:0] pmem_wdata
);

    // no request in the first cycle out of reset
    reset_release: assert property (@(posedge clk)
        $fell(reset) |-> !pmem_read && !pmem_write)
        else $error("memory request in the first cycle after reset");

    first_fetch: assert property (@(posedge clk)
        $fell(reset) |=> pmem_read && pmem_address == `LC3B_RESET_PC)
        else $error("first access is not a read of the reset pc");

    no_read_write: assert property (@(posedge clk) disable iff (reset)
        !(pmem_read && pmem_write))
        else $error("read and write requested together");

    // request held with a stable address until resp
    read_held: assert property (@(posedge clk) disable iff (reset)
        (pmem_read && !pmem_resp) |=> pmem_read && $stable(pmem_address))
        else $error("read dropped or address changed before resp");

    write_held: assert property (@(posedge clk) disable iff (reset)
        (pmem_write && !pmem_resp)
            |=> pmem_write && $stable(pmem_address) && $stable(pmem_wdata))
        else $error("write dropped or address or data changed before resp");

endmodule

bind mp3 mp3_checker checker_int (
    .clk(clk),
    .reset(reset),
    .pmem_resp(pmem_resp),
    .pmem_read(pmem_read),
    .pmem_write(pmem_write),
    .pmem_address(pmem_address),
    .pmem_wdata(pmem_wdata)
);

/* dv/mp3_tb.sv */
`timescale 1ns/1ps
`include "lc3b_config.svh"

module mp3_tb;

    localparam int reset_cycles = 16;
    localparam logic [15:0] table_base = 16'hffc0;
    localparam logic [3:0] opc_add = 4'b0001;
    localparam logic [3:0] opc_and = 4'b0101;
    localparam logic [3:0] opc_not = 4'b1001;
    localparam logic [3:0] opc_ldr = 4'b0110;
    localparam logic [3:0] opc_str = 4'b0111;

    logic clk = 1'b0;
    logic reset;
    logic pmem_resp = 1'b0;
    lc3b_types::lc3b_word pmem_rdata = '0;
    logic pmem_read;
    logic pmem_write;
    lc3b_types::lc3b_word pmem_address;
    lc3b_types::lc3b_word pmem_wdata;

    lc3b_types::lc3b_word mem [0:32767];
    lc3b_types::lc3b_word prog [$];
    lc3b_types::lc3b_word exp_addr [$];
    lc3b_types::lc3b_word exp_data [$];
    integer seed = 36;
    int errors = 0;
    int store_idx = 0;
    int fetch_count = 0;
    lc3b_types::lc3b_word last_fetch;
    logic busy = 1'b0;
    logic [1:0] wait_left;
    logic [31:0] draw;
    int cycles;
    int limit;
    logic timed_out;

    mp3 uut (
        .clk(clk),
        .reset(reset),
        .pmem_resp(pmem_resp),
        .pmem_rdata(pmem_rdata),
        .pmem_read(pmem_read),
        .pmem_write(pmem_write),
        .pmem_address(pmem_address),
        .pmem_wdata(pmem_wdata)
    );

    always #50 clk = ~clk;

    function automatic int pick(input int n);
        logic [31:0] v;
        v = $random(seed);
        return int'(v % n);
    endfunction

    function automatic logic [15:0] alu_word(input logic [3:0] op, input logic [2:0] dr,
                                             input logic [2:0] sr1, input logic imm,
                                             input logic [4:0] low5);
        return {op, dr, sr1, imm, low5};
    endfunction

    function automatic logic [15:0] mem_word(input logic [3:0] op, input logic [2:0] r,
                                             input logic [5:0] off6);
        // r7 stays zero, so offsets are absolute addresses near the top of memory
        return {op, r, 3'd7, off6};
    endfunction

    task automatic build_program();
        logic [2:0] a;
        logic [2:0] b;
        logic [2:0] c;
        for (int r = 0; r < 7; r++) begin
            prog.push_back(alu_word(opc_add, 3'(r), 3'(r), 1'b1, 5'(pick(32))));
        end
        for (int i = 0; i < 24; i++) begin
            a = 3'(pick(7));
            b = 3'(pick(7));
            c = 3'(pick(7));
            case (pick(6))
                0: prog.push_back(alu_word(opc_add, a, b, 1'b0, {2'b00, c}));
                1: prog.push_back(alu_word(opc_add, a, b, 1'b1, 5'(pick(32))));
                2: prog.push_back(alu_word(opc_and, a, b, 1'b0, {2'b00, c}));
                3: prog.push_back(alu_word(opc_and, a, b, 1'b1, 5'(pick(32))));
                4: prog.push_back({opc_not, a, b, 6'h3f});
                default: prog.push_back(mem_word(opc_str, a, 6'(pick(16) - 16)));
            endcase
        end
        // trap, retired as a bubble
        prog.push_back(16'hf025);
        for (int i = 0; i < 6; i++) begin
            a = 3'(pick(7));
            b = 3'(pick(7));
            c = 3'(pick(7));
            prog.push_back(alu_word(opc_add, a, b, 1'b1, 5'(pick(32))));
            if (i % 2 == 0) begin
                prog.push_back(alu_word(opc_and, c, a, 1'b0, {2'b00, a}));
            end else begin
                prog.push_back({opc_not, c, a, 6'h3f});
            end
            prog.push_back(mem_word(opc_str, c, 6'(i - 16)));
        end
        // load then use right away
        for (int i = 0; i < 8; i++) begin
            a = 3'(pick(7));
            b = 3'(pick(7));
            prog.push_back(mem_word(opc_ldr, a, 6'(i - 32)));
            prog.push_back(alu_word(opc_add, b, a, 1'b0, {2'b00, a}));
        end
        for (int r = 0; r < 8; r++) begin
            prog.push_back(mem_word(opc_str, 3'(r), 6'(r - 16)));
        end
        repeat (4) prog.push_back(16'h0000);
    endtask

    task automatic load_memory();
        for (int i = 0; i < 32768; i++) begin
            mem[15'(i)] = 16'(i * 2) ^ 16'ha5c3;
        end
        for (int i = 0; i < 16; i++) begin
            mem[15'(int'(table_base[15:1]) + i)] = 16'($random(seed));
        end
        for (int i = 0; i < prog.size(); i++) begin
            mem[15'(int'(`LC3B_RESET_PC >> 1) + i)] = prog[i];
        end
    endtask

    // in-order ISA model, gives the store stream
    task automatic run_reference();
        logic [15:0] regs [8];
        logic [15:0] ir;
        logic [15:0] op_b;
        logic [15:0] addr;
        regs = '{default: '0};
        foreach (prog[i]) begin
            ir = prog[i];
            op_b = ir[5] ? {{11{ir[4]}}, ir[4:0]} : regs[ir[2:0]];
            addr = regs[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
            case (ir[15:12])
                opc_add: regs[ir[11:9]] = regs[ir[8:6]] + op_b;
                opc_and: regs[ir[11:9]] = regs[ir[8:6]] & op_b;
                opc_not: regs[ir[11:9]] = ~regs[ir[8:6]];
                opc_ldr: regs[ir[11:9]] = mem[addr[15:1]];
                opc_str: begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(regs[ir[11:9]]);
                end
                default: begin
                end
            endcase
        end
    endtask

    task automatic check_store();
        if (store_idx >= exp_addr.size()) begin
            $display("store to %h with data %h when no more stores were expected",
                     pmem_address, pmem_wdata);
            errors++;
        end else begin
            assert (pmem_address == exp_addr[store_idx]) else begin
                $display("Fail at %0d ns: pmem_address is %h, expected %h",
                         $time, pmem_address, exp_addr[store_idx]);
                errors++;
            end
            assert (pmem_wdata == exp_data[store_idx]) else begin
                $display("Fail at %0d ns: pmem_wdata is %h, expected %h",
                         $time, pmem_wdata, exp_data[store_idx]);
                errors++;
            end
            store_idx++;
        end
    endtask

    // same address while stalled, else the next word
    task automatic check_fetch();
        if (fetch_count > 0) begin
            assert (pmem_address == last_fetch || pmem_address == last_fetch + 16'd2) else begin
                $display("Fail at %0d ns: pmem_address is %h, expected %h or %h",
                         $time, pmem_address, last_fetch, last_fetch + 16'd2);
                errors++;
            end
        end
        last_fetch = pmem_address;
        fetch_count++;
    endtask

    task automatic serve_access();
        if (pmem_write) begin
            mem[pmem_address[15:1]] = pmem_wdata;
            check_store();
        end else begin
            pmem_rdata <= mem[pmem_address[15:1]];
            if (pmem_address[15:12] != 4'hf) begin
                check_fetch();
            end
        end
        pmem_resp <= 1'b1;
    endtask

    // memory model, 0 to 3 wait cycles per access
    always @(posedge clk) begin
        if (reset) begin
            pmem_resp <= 1'b0;
            busy <= 1'b0;
        end else if (pmem_resp) begin
            // request still visible here is the one just answered
            pmem_resp <= 1'b0;
        end else if (busy) begin
            if (wait_left == 2'd0) begin
                busy <= 1'b0;
                serve_access();
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end else if (pmem_read || pmem_write) begin
            draw = $random(seed);
            if (draw[1:0] == 2'd0) begin
                serve_access();
            end else begin
                busy <= 1'b1;
                wait_left <= draw[1:0] - 2'd1;
            end
        end
    end

    initial begin
        reset = 1'b1;
        timed_out = 1'b0;
        cycles = 0;
        build_program();
        load_memory();
        run_reference();
        limit = prog.size() * 4 * 6 + reset_cycles;
        repeat (reset_cycles) begin
            @(posedge clk);
            cycles++;
        end
        reset <= 1'b0;
        while (store_idx < exp_addr.size() && !timed_out) begin
            @(posedge clk);
            cycles++;
            timed_out = (cycles >= limit);
        end
        if (timed_out) begin
            $display("timeout after %0d cycles, only %0d of %0d stores reached memory",
                     cycles, store_idx, exp_addr.size());
        end
        $display("%0d errors, %0d of %0d stores checked, %0d fetches checked",
                 errors + int'(timed_out), store_idx, exp_addr.size(), fetch_count);
        if (errors == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* mp3.f */
+incdir+logic
logic/lc3b_types.sv
logic/mem_port_if.sv
logic/pipe_reg.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/mem_stage.sv
logic/arbiter.sv
logic/mp3.sv
dv/mp3_checker.sv
dv/mp3_tb.sv

/* run_sim.sh */
#!/bin/sh
verilator --binary --assert -f mp3.f --top-module mp3_tb -o mp3_sim || exit 1
./obj_dir/mp3_sim > sim.log 2>&1
status=$?
cat sim.log
[ $status -eq 0 ] && ! grep -q "Something failed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
